//--- src/bank_pkg.sv
`default_nettype none

package bank_pkg;

    // geometry of one bank and the region split
    localparam int BANK_DEPTH    = 128;
    localparam int FIFO_ROWS     = 32;
    localparam int FIFO_CAPACITY = 2 * FIFO_ROWS;
    localparam int NUM_FIFOS     = 3;

    typedef logic [31:0] data_t;
    // bit 0 bank, bits 5:1 row offset
    typedef logic [5:0]  addr_t;
    typedef logic [6:0]  row_t;
    // value 3 is not a fifo
    typedef logic [1:0]  fifo_id_t;
    typedef logic [5:0]  slot_t;
    typedef logic [6:0]  count_t;

    // row bases, same in both banks
    localparam row_t FIFO0_BASE  = row_t'(0);
    localparam row_t FIFO1_BASE  = row_t'(FIFO_ROWS);
    localparam row_t FIFO2_BASE  = row_t'(2 * FIFO_ROWS);
    localparam row_t RANDOM_BASE = row_t'(NUM_FIFOS * FIFO_ROWS);

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_FIFO_PUSH,
        OP_FIFO_POP,
        OP_FLUSH,
        OP_RAND_WR,
        OP_RAND_RD
    } op_e;

    typedef struct packed {
        op_e      op;
        fifo_id_t fifo;
        addr_t    addr;
        data_t    data;
    } cmd_t;

    typedef struct packed {
        logic  en;
        logic  we;
        row_t  row;
        data_t data;
    } bank_req_t;

    typedef struct packed {
        logic  valid;
        data_t data;
    } rd_resp_t;

endpackage

`default_nettype wire

//--- src/cmd_capture.sv
`default_nettype none
`timescale 1ns/1ps

module cmd_capture (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,
    input  logic               pattern_i,
    input  logic               we_i,
    input  logic               re_i,
    input  logic               flush_i,
    input  bank_pkg::fifo_id_t fifo_sel_i,
    input  bank_pkg::addr_t    addr_i,
    input  bank_pkg::data_t    din_i,
    output bank_pkg::cmd_t     cmd_o
);
    import bank_pkg::*;

    op_e      op_next;
    op_e      op_q;
    fifo_id_t fifo_q;
    addr_t    addr_q;
    data_t    data_q;

    // one command per cycle, flush wins in fifo mode
    always_comb begin
        op_next = OP_IDLE;
        if (!en_i || (pattern_i && fifo_sel_i >= fifo_id_t'(NUM_FIFOS))) begin
            op_next = OP_IDLE;
        end else if (pattern_i && flush_i) begin
            op_next = OP_FLUSH;
        end else if (we_i) begin
            op_next = pattern_i ? OP_FIFO_PUSH : OP_RAND_WR;
        end else if (re_i) begin
            op_next = pattern_i ? OP_FIFO_POP : OP_RAND_RD;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= OP_IDLE;
        end else begin
            op_q <= op_next;
        end
    end

    // payload follows the inputs, meaning comes from op
    always_ff @(posedge clk) begin
        fifo_q <= fifo_sel_i;
        addr_q <= addr_i;
        data_q <= din_i;
    end

    assign cmd_o = '{op: op_q, fifo: fifo_q, addr: addr_q, data: data_q};

    // single-port banks cannot take a write and a read together
    a_no_wr_rd: assert property (@(posedge clk) disable iff (rst)
        en_i |-> !(we_i && re_i));

endmodule

`default_nettype wire

//--- src/fifo_ptr_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module fifo_ptr_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            push_i,
    input  logic            pop_i,
    input  logic            flush_i,
    output logic            grant_o,
    output bank_pkg::slot_t slot_o
);
    import bank_pkg::*;

    slot_t  wr_ptr_q;
    slot_t  rd_ptr_q;
    count_t count_q;
    logic   push_ok;
    logic   pop_ok;

    // full and empty come from the count alone
    assign push_ok = push_i && (count_q < count_t'(FIFO_CAPACITY));
    assign pop_ok  = pop_i && (count_q != '0);
    assign grant_o = push_ok || pop_ok;

    // entry index that the bank access uses this cycle
    assign slot_o = push_i ? wr_ptr_q : rd_ptr_q;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (push_ok) begin
            // pointer wraps at 64 on its own
            wr_ptr_q <= wr_ptr_q + slot_t'(1);
            count_q  <= count_q + count_t'(1);
        end else if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + slot_t'(1);
            count_q  <= count_q - count_t'(1);
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count_q <= count_t'(FIFO_CAPACITY));

endmodule

`default_nettype wire

//--- src/bank_access_stage.sv
`default_nettype none
`timescale 1ns/1ps

module bank_access_stage (
    input  logic                clk,
    input  logic                rst,
    input  bank_pkg::cmd_t      cmd_i,
    output bank_pkg::bank_req_t req0_o,
    output bank_pkg::bank_req_t req1_o
);
    import bank_pkg::*;

    logic [NUM_FIFOS-1:0] fifo_oh;
    logic [NUM_FIFOS-1:0] push_s;
    logic [NUM_FIFOS-1:0] pop_s;
    logic [NUM_FIFOS-1:0] flush_s;
    logic [NUM_FIFOS-1:0] grant_s;
    slot_t                slot0;
    slot_t                slot1;
    slot_t                slot2;

    logic  fifo_grant;
    slot_t fifo_slot;
    row_t  fifo_base;
    logic  is_fifo_op;
    logic  is_rand_op;
    logic  hit;
    logic  bank_sel;
    row_t  row_d;

    logic [1:0] en_q;
    logic       we_q;
    row_t       row_q;
    data_t      data_q;

    // strobes go only to the selected fifo
    assign fifo_oh = NUM_FIFOS'(1) << cmd_i.fifo;
    assign push_s  = fifo_oh & {NUM_FIFOS{cmd_i.op == OP_FIFO_PUSH}};
    assign pop_s   = fifo_oh & {NUM_FIFOS{cmd_i.op == OP_FIFO_POP}};
    assign flush_s = fifo_oh & {NUM_FIFOS{cmd_i.op == OP_FLUSH}};

    fifo_ptr_ctrl u_fifo0 (
        .clk     (clk),
        .rst     (rst),
        .push_i  (push_s[0]),
        .pop_i   (pop_s[0]),
        .flush_i (flush_s[0]),
        .grant_o (grant_s[0]),
        .slot_o  (slot0)
    );

    fifo_ptr_ctrl u_fifo1 (
        .clk     (clk),
        .rst     (rst),
        .push_i  (push_s[1]),
        .pop_i   (pop_s[1]),
        .flush_i (flush_s[1]),
        .grant_o (grant_s[1]),
        .slot_o  (slot1)
    );

    fifo_ptr_ctrl u_fifo2 (
        .clk     (clk),
        .rst     (rst),
        .push_i  (push_s[2]),
        .pop_i   (pop_s[2]),
        .flush_i (flush_s[2]),
        .grant_o (grant_s[2]),
        .slot_o  (slot2)
    );

    always_comb begin
        fifo_grant = 1'b0;
        fifo_slot  = slot0;
        fifo_base  = FIFO0_BASE;
        case (cmd_i.fifo)
            2'd0: begin
                fifo_grant = grant_s[0];
                fifo_slot  = slot0;
                fifo_base  = FIFO0_BASE;
            end
            2'd1: begin
                fifo_grant = grant_s[1];
                fifo_slot  = slot1;
                fifo_base  = FIFO1_BASE;
            end
            2'd2: begin
                fifo_grant = grant_s[2];
                fifo_slot  = slot2;
                fifo_base  = FIFO2_BASE;
            end
            default: fifo_grant = 1'b0;
        endcase
    end

    assign is_fifo_op = (cmd_i.op == OP_FIFO_PUSH) || (cmd_i.op == OP_FIFO_POP);
    assign is_rand_op = (cmd_i.op == OP_RAND_WR) || (cmd_i.op == OP_RAND_RD);

    // slot bit 0 or addr bit 0 picks the bank, rejected ops drop out here
    assign hit      = (is_fifo_op && fifo_grant) || is_rand_op;
    assign bank_sel = is_fifo_op ? fifo_slot[0] : cmd_i.addr[0];
    assign row_d    = is_fifo_op ? fifo_base + row_t'(fifo_slot[5:1])
                                 : RANDOM_BASE + row_t'(cmd_i.addr[5:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q <= '0;
        end else begin
            en_q[0] <= hit && !bank_sel;
            en_q[1] <= hit && bank_sel;
        end
    end

    // only one bank is active per cycle, so both share the payload
    always_ff @(posedge clk) begin
        we_q   <= (cmd_i.op == OP_FIFO_PUSH) || (cmd_i.op == OP_RAND_WR);
        row_q  <= row_d;
        data_q <= cmd_i.data;
    end

    assign req0_o = '{en: en_q[0], we: we_q, row: row_q, data: data_q};
    assign req1_o = '{en: en_q[1], we: we_q, row: row_q, data: data_q};

    a_one_bank: assert property (@(posedge clk) disable iff (rst)
        !(req0_o.en && req1_o.en));

endmodule

`default_nettype wire

//--- src/sram_bank.sv
`default_nettype none
`timescale 1ns/1ps

module sram_bank (
    input  logic            clk,
    input  logic            en_i,
    input  logic            we_i,
    input  bank_pkg::row_t  row_i,
    input  bank_pkg::data_t din_i,
    output bank_pkg::data_t dout_o
);
    import bank_pkg::*;

    // behavioural stand-in for the 128x32 macro
    data_t mem [BANK_DEPTH];

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[row_i] <= din_i;
            end else begin
                dout_o <= mem[row_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/read_return.sv
`default_nettype none
`timescale 1ns/1ps

module read_return (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd0_i,
    input  logic               rd1_i,
    input  bank_pkg::data_t    data0_i,
    input  bank_pkg::data_t    data1_i,
    output bank_pkg::rd_resp_t resp_o
);
    import bank_pkg::*;

    logic  rd0_q;
    logic  rd1_q;
    logic  valid_q;
    data_t data_q;

    // flags line up with the bank output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd0_q <= 1'b0;
            rd1_q <= 1'b0;
        end else begin
            rd0_q <= rd0_i;
            rd1_q <= rd1_i;
        end
    end

    // all ones when nothing comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            data_q  <= '1;
        end else begin
            valid_q <= rd0_q || rd1_q;
            data_q  <= rd0_q ? data0_i : (rd1_q ? data1_i : '1);
        end
    end

    assign resp_o = '{valid: valid_q, data: data_q};

    a_one_read: assert property (@(posedge clk) disable iff (rst)
        !(rd0_q && rd1_q));

endmodule

`default_nettype wire

//--- src/bankgroup_top.sv
`default_nettype none
`timescale 1ns/1ps

module bankgroup_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,
    input  logic               pattern_i,
    input  logic               we_i,
    input  logic               re_i,
    input  logic               flush_i,
    input  bank_pkg::fifo_id_t fifo_sel_i,
    input  bank_pkg::addr_t    addr_i,
    input  bank_pkg::data_t    din_i,
    output bank_pkg::rd_resp_t dout_o
);
    import bank_pkg::*;

    cmd_t      cmd;
    bank_req_t req0;
    bank_req_t req1;
    data_t     data0;
    data_t     data1;
    logic      rd0;
    logic      rd1;

    cmd_capture u_cmd_capture (
        .clk        (clk),
        .rst        (rst),
        .en_i       (en_i),
        .pattern_i  (pattern_i),
        .we_i       (we_i),
        .re_i       (re_i),
        .flush_i    (flush_i),
        .fifo_sel_i (fifo_sel_i),
        .addr_i     (addr_i),
        .din_i      (din_i),
        .cmd_o      (cmd)
    );

    bank_access_stage u_bank_access (
        .clk    (clk),
        .rst    (rst),
        .cmd_i  (cmd),
        .req0_o (req0),
        .req1_o (req1)
    );

    sram_bank u_bank0 (
        .clk    (clk),
        .en_i   (req0.en),
        .we_i   (req0.we),
        .row_i  (req0.row),
        .din_i  (req0.data),
        .dout_o (data0)
    );

    sram_bank u_bank1 (
        .clk    (clk),
        .en_i   (req1.en),
        .we_i   (req1.we),
        .row_i  (req1.row),
        .din_i  (req1.data),
        .dout_o (data1)
    );

    // a read is an enabled request without write
    assign rd0 = req0.en && !req0.we;
    assign rd1 = req1.en && !req1.we;

    read_return u_read_return (
        .clk     (clk),
        .rst     (rst),
        .rd0_i   (rd0),
        .rd1_i   (rd1),
        .data0_i (data0),
        .data1_i (data1),
        .resp_o  (dout_o)
    );

endmodule

`default_nettype wire

//--- test/tb_bankgroup.sv
`default_nettype none
`timescale 1ns/1ps

module tb_bankgroup;
    import bank_pkg::*;

    // roughly four times the cycles that all tests take
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int READ_LATENCY   = 3;

    typedef struct packed {
        logic [31:0] due;
        logic        valid;
        data_t       data;
    } expect_t;

    logic     clk;
    logic     rst;
    logic     en_i;
    logic     pattern_i;
    logic     we_i;
    logic     re_i;
    logic     flush_i;
    fifo_id_t fifo_sel_i;
    addr_t    addr_i;
    data_t    din_i;
    rd_resp_t dout_o;

    int      cyc = 0;
    expect_t exp_q[$];
    data_t   fifo_model[NUM_FIFOS][$];
    data_t   rand_model[64];

    bankgroup_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .en_i       (en_i),
        .pattern_i  (pattern_i),
        .we_i       (we_i),
        .re_i       (re_i),
        .flush_i    (flush_i),
        .fifo_sel_i (fifo_sel_i),
        .addr_i     (addr_i),
        .din_i      (din_i),
        .dout_o     (dout_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout after %0d cycles, tests did not finish", cyc));
        end
    end

    task automatic drive_cmd(input logic en, input logic pat, input logic we, input logic re,
                             input logic fl, input fifo_id_t sel, input addr_t addr,
                             input data_t din);
        @(negedge clk);
        en_i       = en;
        pattern_i  = pat;
        we_i       = we;
        re_i       = re;
        flush_i    = fl;
        fifo_sel_i = sel;
        addr_i     = addr;
        din_i      = din;
    endtask

    // called right after the drive, while cyc still names the previous edge
    task automatic expect_read(input logic valid, input data_t data);
        exp_q.push_back('{due: 32'(cyc + 1 + READ_LATENCY), valid: valid, data: data});
    endtask

    task automatic rand_write(input addr_t addr, input data_t data);
        drive_cmd(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0, addr, data);
        rand_model[addr] = data;
    endtask

    task automatic rand_read(input addr_t addr);
        drive_cmd(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0, addr, '0);
        expect_read(1'b1, rand_model[addr]);
    endtask

    task automatic fifo_push(input fifo_id_t f, input data_t data);
        drive_cmd(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, f, '0, data);
        // a full fifo drops the word
        if (fifo_model[f].size() < FIFO_CAPACITY)
            fifo_model[f].push_back(data);
    endtask

    task automatic fifo_pop(input fifo_id_t f);
        drive_cmd(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, f, '0, '0);
        if (fifo_model[f].size() != 0)
            expect_read(1'b1, fifo_model[f].pop_front());
        else
            expect_read(1'b0, '1);
    endtask

    task automatic fifo_flush(input fifo_id_t f);
        drive_cmd(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, f, '0, '0);
        fifo_model[f].delete();
    endtask

    task automatic drain();
        drive_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, '0, '0);
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic check_response(input expect_t e);
        if (e.valid) begin
            assert (dout_o.valid) else
                report_error($sformatf("missing response on dout_o at %0t", $time));
            assert (dout_o.data == e.data) else
                report_error($sformatf("mismatch at %0t: dout_o.data got %h expected %h",
                                       $time, dout_o.data, e.data));
        end else begin
            assert (!dout_o.valid) else
                report_error($sformatf("response at %0t for a read that must be dropped",
                                       $time));
            assert (dout_o.data == '1) else
                report_error($sformatf("mismatch at %0t: dout_o.data got %h expected %h",
                                       $time, dout_o.data, 32'hffff_ffff));
        end
    endtask

    // dout_o only changes on the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                check_response(exp_q.pop_front());
            end else begin
                assert (!dout_o.valid) else
                    report_error($sformatf("unexpected response on dout_o at %0t", $time));
            end
        end
    end

    task automatic scratch_readback();
        addr_t addrs[10];
        addrs = '{6'd0, 6'd1, 6'd7, 6'd12, 6'd21, 6'd30, 6'd33, 6'd44, 6'd58, 6'd63};
        for (int i = 0; i < 10; i++)
            rand_write(addrs[i], $urandom());
        for (int i = 9; i >= 0; i--)
            rand_read(addrs[i]);
        drain();
    endtask

    task automatic interleaved_order();
        for (int i = 0; i < 6; i++)
            for (int f = 0; f < NUM_FIFOS; f++)
                fifo_push(fifo_id_t'(f), $urandom());
        for (int f = 0; f < NUM_FIFOS; f++)
            for (int i = 0; i < 6; i++)
                fifo_pop(fifo_id_t'(f));
        drain();
    endtask

    task automatic full_and_empty_limits();
        fifo_pop(2'd2);
        // pointers start mid-region here, so the 64 entries wrap
        for (int i = 0; i < FIFO_CAPACITY + 1; i++)
            fifo_push(2'd0, $urandom());
        for (int i = 0; i < FIFO_CAPACITY + 1; i++)
            fifo_pop(2'd0);
        drain();
    endtask

    task automatic flush_one_of_two();
        for (int i = 0; i < 5; i++) begin
            fifo_push(2'd0, $urandom());
            fifo_push(2'd1, $urandom());
        end
        fifo_flush(2'd1);
        fifo_pop(2'd1);
        for (int i = 0; i < 5; i++)
            fifo_pop(2'd0);
        drain();
    endtask

    task automatic region_isolation();
        for (int a = 0; a < 64; a++)
            rand_write(addr_t'(a), $urandom());
        for (int f = 0; f < NUM_FIFOS; f++)
            for (int i = 0; i < FIFO_CAPACITY; i++)
                fifo_push(fifo_id_t'(f), $urandom());
        // en_i low or fifo 3 must leave banks and pointers alone
        drive_cmd(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 6'd5, $urandom());
        drive_cmd(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0, 6'd9, '0);
        drive_cmd(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd1, '0, '0);
        drive_cmd(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 2'd2, '0, '0);
        drive_cmd(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 2'd3, '0, '0);
        drive_cmd(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd3, '0, '0);
        for (int a = 0; a < 64; a++)
            rand_read(addr_t'(a));
        for (int f = 0; f < NUM_FIFOS; f++)
            for (int i = 0; i < FIFO_CAPACITY + 1; i++)
                fifo_pop(fifo_id_t'(f));
        drain();
    endtask

    task automatic back_to_back_reads();
        for (int i = 0; i < 4; i++)
            fifo_push(2'd2, $urandom());
        for (int i = 0; i < 4; i++) begin
            rand_read(addr_t'(i * 9));
            fifo_pop(2'd2);
        end
        rand_read(6'd62);
        rand_read(6'd3);
        drain();
    endtask

    initial begin
        void'($urandom(32'hd330));
        rst        = 1'b1;
        en_i       = 1'b0;
        pattern_i  = 1'b0;
        we_i       = 1'b0;
        re_i       = 1'b0;
        flush_i    = 1'b0;
        fifo_sel_i = '0;
        addr_i     = '0;
        din_i      = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        scratch_readback();
        interleaved_order();
        full_and_empty_limits();
        flush_one_of_two();
        region_isolation();
        back_to_back_reads();

        if (exp_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_error("reads still wait for a response at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- tb.f
src/bank_pkg.sv
src/cmd_capture.sv
src/fifo_ptr_ctrl.sv
src/bank_access_stage.sv
src/sram_bank.sv
src/read_return.sv
src/bankgroup_top.sv
test/tb_bankgroup.sv

//--- run.sh
#!/bin/sh
# build and run the bank group testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_bankgroup

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_bankgroup -f tb.f -o tb_bankgroup; then
    echo "compile failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "^STATUS: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
